/* logic/lsu_pkg.sv */
package lsu_pkg;

    // ------------------------------
    // widths
    // ------------------------------
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // ------------------------------
    // rv32i opcodes
    // ------------------------------
    localparam logic [6:0] OPCODE_LOAD  = 7'b0000011;
    localparam logic [6:0] OPCODE_STORE = 7'b0100011;
    localparam logic [6:0] OPCODE_OP    = 7'b0110011;

    // ------------------------------
    // funct3 size and sign codes
    // ------------------------------
    // stores only use the b, h and w codes
    localparam logic [2:0] F3_B  = 3'b000;
    localparam logic [2:0] F3_H  = 3'b001;
    localparam logic [2:0] F3_W  = 3'b010;
    localparam logic [2:0] F3_BU = 3'b100;
    localparam logic [2:0] F3_HU = 3'b101;

    // ------------------------------
    // pipeline payloads
    // ------------------------------
    // execute to memory
    // wdata is the alu result, or the store data for stores
    typedef struct packed {
        logic [6:0]            opcode;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic                  wreg;
        logic [XLEN-1:0]       wdata;
        logic [XLEN-1:0]       addr;
    } ex_mem_t;

    // memory to writeback
    typedef struct packed {
        logic [REG_ADDR_W-1:0] rd;
        logic                  wreg;
        logic [XLEN-1:0]       wdata;
    } mem_wb_t;

endpackage

/* logic/byte_bus_if.sv */
`timescale 1ns/100ps

// byte wide wishbone classic bus
interface byte_bus_if #(
    parameter int ADDR_W = 10
);

    logic              cyc;
    logic              stb;
    logic              we;
    logic [ADDR_W-1:0] adr;
    logic [7:0]        dat_w;
    logic [7:0]        dat_r;
    logic              ack;

    modport master (
        output cyc,
        output stb,
        output we,
        output adr,
        output dat_w,
        input  dat_r,
        input  ack
    );

    modport slave (
        input  cyc,
        input  stb,
        input  we,
        input  adr,
        input  dat_w,
        output dat_r,
        output ack
    );

endinterface

/* logic/pipe_reg.sv */
`timescale 1ns/100ps

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,

    input  logic     stall_i,

    input  payload_t d_i,
    input  logic     d_valid_i,

    output payload_t q_o,
    output logic     q_valid_o
);

    // valid bit
    // an empty d_valid_i on stall release loads a bubble
    always_ff @(posedge clk) begin
        if (rst) begin
            q_valid_o <= 1'b0;
        end else if (!stall_i) begin
            q_valid_o <= d_valid_i;
        end
    end

    // payload only moves with a valid item
    always_ff @(posedge clk) begin
        if (!stall_i && d_valid_i) begin
            q_o <= d_i;
        end
    end

endmodule

/* logic/mem_access_seq.sv */
`timescale 1ns/100ps

module mem_access_seq
    import lsu_pkg::*;
#(
    parameter int ADDR_W = 10
) (
    input  logic       clk,
    input  logic       rst,

    // item held in the ex_mem register
    input  ex_mem_t    in_i,
    input  logic       in_valid_i,

    // byte bus towards the ram
    byte_bus_if.master bus,

    // hold the ex_mem register and the source
    output logic       stall_o,

    // result towards the mem_wb register
    output mem_wb_t    out_o,
    output logic       out_valid_o
);

    logic              is_load_op;
    logic              is_store_op;
    logic              mem_active;
    logic [1:0]        last_idx;
    logic [1:0]        cnt;
    logic              last_ack;
    logic [ADDR_W-1:0] base_adr;
    logic [23:0]       rd_buf;
    logic [XLEN-1:0]   raw_word;
    logic [XLEN-1:0]   load_word;

    // ------------------------------
    // decode
    // ------------------------------
    assign is_load_op  = (in_i.opcode == OPCODE_LOAD);
    assign is_store_op = (in_i.opcode == OPCODE_STORE);
    assign mem_active  = in_valid_i && (is_load_op || is_store_op);

    // index of the final byte of the access
    always_comb begin
        case (in_i.funct3)
            F3_B, F3_BU: begin
                last_idx = 2'd0;
            end
            F3_H, F3_HU: begin
                last_idx = 2'd1;
            end
            F3_W: begin
                last_idx = 2'd3;
            end
            default: begin
                last_idx = 2'd3;
            end
        endcase
    end

    assign last_ack = mem_active && bus.ack && (cnt == last_idx);

    // ------------------------------
    // byte transfers
    // ------------------------------
    // only the low address bits reach the ram, so accesses wrap
    assign base_adr = in_i.addr[ADDR_W-1:0];

    // cyc and stb stay up over the whole sequence
    // the ram only acks once per byte, so the next byte starts after ack
    assign bus.cyc   = mem_active;
    assign bus.stb   = mem_active;
    assign bus.we    = mem_active && is_store_op;
    assign bus.adr   = base_adr + ADDR_W'(cnt);
    assign bus.dat_w = in_i.wdata[8*cnt +: 8];

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt <= 2'd0;
        end else if (mem_active && bus.ack) begin
            if (last_ack) begin
                cnt <= 2'd0;
            end else begin
                cnt <= cnt + 2'd1;
            end
        end
    end

    // collect every load byte except the last one
    always_ff @(posedge clk) begin
        if (mem_active && is_load_op && bus.ack && !last_ack) begin
            case (cnt)
                2'd0: begin
                    rd_buf[7:0] <= bus.dat_r;
                end
                2'd1: begin
                    rd_buf[15:8] <= bus.dat_r;
                end
                default: begin
                    rd_buf[23:16] <= bus.dat_r;
                end
            endcase
        end
    end

    // ------------------------------
    // load data
    // ------------------------------
    // last byte is taken straight from the bus in the ack cycle
    always_comb begin
        case (last_idx)
            2'd0: begin
                raw_word = {24'h000000, bus.dat_r};
            end
            2'd1: begin
                raw_word = {16'h0000, bus.dat_r, rd_buf[7:0]};
            end
            default: begin
                raw_word = {bus.dat_r, rd_buf};
            end
        endcase
    end

    always_comb begin
        case (in_i.funct3)
            F3_B: begin
                load_word = {{24{raw_word[7]}}, raw_word[7:0]};
            end
            F3_H: begin
                load_word = {{16{raw_word[15]}}, raw_word[15:0]};
            end
            default: begin
                // unsigned and word loads are already zero filled
                load_word = raw_word;
            end
        endcase
    end

    // ------------------------------
    // result and stall
    // ------------------------------
    assign stall_o = mem_active && !last_ack;

    always_comb begin
        out_o.rd    = in_i.rd;
        out_o.wreg  = is_store_op ? 1'b0 : in_i.wreg;
        out_o.wdata = is_load_op ? load_word : in_i.wdata;
    end

    // memory items finish with the last ack, others go straight through
    assign out_valid_o = mem_active ? last_ack : in_valid_i;

endmodule

/* logic/byte_ram.sv */
`timescale 1ns/100ps

module byte_ram #(
    parameter int ADDR_W = 10
) (
    input  logic      clk,
    input  logic      rst,

    byte_bus_if.slave bus
);

    localparam int DEPTH = 2 ** ADDR_W;

    logic [7:0] mem [DEPTH];
    logic       ack_q;
    logic [7:0] rdata_q;
    logic       req;

    // ------------------------------
    // storage
    // ------------------------------
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = 8'h00;
        end
    end

    // a request is only taken when no ack is pending,
    // so a held stb in the ack cycle does not start a second transfer
    assign req = bus.cyc && bus.stb && !ack_q;

    always_ff @(posedge clk) begin
        if (req && bus.we) begin
            mem[bus.adr] <= bus.dat_w;
        end
    end

    // ------------------------------
    // read data and ack
    // ------------------------------
    always_ff @(posedge clk) begin
        if (req && !bus.we) begin
            rdata_q <= mem[bus.adr];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req;
        end
    end

    assign bus.ack   = ack_q;
    assign bus.dat_r = rdata_q;

endmodule

/* logic/mem_stage_top.sv */
`timescale 1ns/100ps

module mem_stage_top
    import lsu_pkg::*;
#(
    parameter int ADDR_W = 10
) (
    input  logic                  clk,
    input  logic                  rst,

    // from execute
    input  logic                  in_valid_i,
    input  logic [6:0]            opcode_i,
    input  logic [2:0]            funct3_i,
    input  logic [REG_ADDR_W-1:0] rd_i,
    input  logic                  wreg_i,
    input  logic [XLEN-1:0]       wdata_i,
    input  logic [XLEN-1:0]       addr_i,
    output logic                  in_ready_o,

    // to writeback
    output logic                  out_valid_o,
    output logic [REG_ADDR_W-1:0] wd_o,
    output logic                  wreg_o,
    output logic [XLEN-1:0]       wdata_o
);

    ex_mem_t ex_mem_d;
    ex_mem_t ex_mem_q;
    logic    ex_mem_valid;
    logic    accept;
    logic    seq_stall;
    mem_wb_t seq_out;
    logic    seq_out_valid;
    mem_wb_t mem_wb_q;
    logic    mem_wb_valid;

    byte_bus_if #(
        .ADDR_W(ADDR_W)
    ) byte_bus ();

    // ------------------------------
    // input side
    // ------------------------------
    assign in_ready_o = !seq_stall;
    assign accept     = in_valid_i && in_ready_o;

    always_comb begin
        ex_mem_d.opcode = opcode_i;
        ex_mem_d.funct3 = funct3_i;
        ex_mem_d.rd     = rd_i;
        ex_mem_d.wreg   = wreg_i;
        ex_mem_d.wdata  = wdata_i;
        ex_mem_d.addr   = addr_i;
    end

    // a finished item is dropped when the stall ends
    // unless a new one is accepted in the same cycle
    pipe_reg #(
        .payload_t(ex_mem_t)
    ) i_ex_mem_reg (
        .clk       (clk),
        .rst       (rst),
        .stall_i   (seq_stall),
        .d_i       (ex_mem_d),
        .d_valid_i (accept),
        .q_o       (ex_mem_q),
        .q_valid_o (ex_mem_valid)
    );

    // ------------------------------
    // memory access
    // ------------------------------
    mem_access_seq #(
        .ADDR_W(ADDR_W)
    ) i_mem_access_seq (
        .clk         (clk),
        .rst         (rst),
        .in_i        (ex_mem_q),
        .in_valid_i  (ex_mem_valid),
        .bus         (byte_bus.master),
        .stall_o     (seq_stall),
        .out_o       (seq_out),
        .out_valid_o (seq_out_valid)
    );

    byte_ram #(
        .ADDR_W(ADDR_W)
    ) i_byte_ram (
        .clk (clk),
        .rst (rst),
        .bus (byte_bus.slave)
    );

    // ------------------------------
    // output side
    // ------------------------------
    // writeback always accepts
    pipe_reg #(
        .payload_t(mem_wb_t)
    ) i_mem_wb_reg (
        .clk       (clk),
        .rst       (rst),
        .stall_i   (1'b0),
        .d_i       (seq_out),
        .d_valid_i (seq_out_valid),
        .q_o       (mem_wb_q),
        .q_valid_o (mem_wb_valid)
    );

    assign out_valid_o = mem_wb_valid;
    assign wd_o        = mem_wb_q.rd;
    assign wreg_o      = mem_wb_q.wreg;
    assign wdata_o     = mem_wb_q.wdata;

endmodule

/* tb/tb_ref_model.svh */
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

typedef struct packed {
    logic [4:0]  rd;
    logic        wreg;
    logic [31:0] wdata;
    logic        check_data;
    logic        fixed_lat;
    logic [31:0] cycle;
} expect_t;

// shadow copy of the ram, zero at start like the dut
logic [7:0]  shadow_mem [2**ADDR_W] = '{default: 8'h00};
logic [31:0] rng_state = 32'd19;

function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
endfunction

// applies one accepted item to the shadow memory and returns its result
function automatic expect_t apply_item(logic [6:0] op, logic [2:0] f3, logic [4:0] rd,
                                       logic wreg, logic [31:0] wdata, logic [31:0] addr);
    expect_t     e;
    int          nbytes;
    logic [31:0] word;
    logic [ADDR_W-1:0] idx;
    e = '{rd: rd, wreg: wreg, wdata: wdata, check_data: 1'b1, fixed_lat: 1'b0, cycle: 0};
    nbytes = (f3 == F3_B || f3 == F3_BU) ? 1 : ((f3 == F3_H || f3 == F3_HU) ? 2 : 4);
    word = 32'h0;
    for (int k = 0; k < nbytes; k++) begin
        idx = addr[ADDR_W-1:0] + ADDR_W'(k);
        if (op == OPCODE_STORE) begin
            shadow_mem[idx] = wdata[8*k +: 8];
        end else begin
            word[8*k +: 8] = shadow_mem[idx];
        end
    end
    if (op == OPCODE_LOAD) begin
        if (f3 == F3_B) begin
            word = {{24{word[7]}}, word[7:0]};
        end else if (f3 == F3_H) begin
            word = {{16{word[15]}}, word[15:0]};
        end
        e.wdata = word;
    end else if (op == OPCODE_STORE) begin
        e.wreg       = 1'b0;
        e.check_data = 1'b0;
    end else begin
        e.fixed_lat = 1'b1;
    end
    return e;
endfunction

`endif

/* tb/tb_mem_stage_top.sv */
`timescale 1ns/100ps

module tb_mem_stage_top
    import lsu_pkg::*;
();

    localparam int ADDR_W     = 10;
    localparam int CLK_PERIOD = 40;
    localparam int N_DIRECTED = 16;
    localparam int N_RANDOM   = 400;
    localparam logic [6:0] OPCODE_OPIMM = 7'b0010011;

    `include "tb_ref_model.svh"

    logic        clk = 1'b0;
    logic        rst;
    logic        in_valid_i;
    logic [6:0]  opcode_i;
    logic [2:0]  funct3_i;
    logic [4:0]  rd_i;
    logic        wreg_i;
    logic [31:0] wdata_i;
    logic [31:0] addr_i;
    logic        in_ready_o;
    logic        out_valid_o;
    logic [4:0]  wd_o;
    logic        wreg_o;
    logic [31:0] wdata_o;

    logic [31:0] cycle_cnt = 0;
    expect_t     expect_q[$];

    mem_stage_top #(
        .ADDR_W(ADDR_W)
    ) i_mem_stage_top (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // 20 cycles per item plus reset
    initial begin
        #((N_DIRECTED + N_RANDOM) * 20 * CLK_PERIOD + 5 * CLK_PERIOD);
        $display("ERROR: the run timed out without finishing");
        $display(">>> FAIL");
        $fatal(1, "timeout");
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display(">>> FAIL");
            $fatal(1, "mismatch");
        end
    endtask

    // drives at the current edge and returns at the edge that accepts the item
    task automatic send_item(input logic [6:0] op, input logic [2:0] f3, input logic [4:0] rd,
                             input logic wreg, input logic [31:0] wdata, input logic [31:0] addr);
        expect_t e;
        in_valid_i <= 1'b1;
        opcode_i   <= op;
        funct3_i   <= f3;
        rd_i       <= rd;
        wreg_i     <= wreg;
        wdata_i    <= wdata;
        addr_i     <= addr;
        @(posedge clk);
        while (!in_ready_o) begin
            @(posedge clk);
        end
        e = apply_item(op, f3, rd, wreg, wdata, addr);
        e.cycle = cycle_cnt;
        expect_q.push_back(e);
    endtask

    task automatic idle_cycles(input int n);
        in_valid_i <= 1'b0;
        repeat (n) @(posedge clk);
    endtask

    // ------------------------------
    // compare
    // ------------------------------
    always @(posedge clk) begin : compare_outputs
        expect_t e;
        if (!rst && out_valid_o) begin
            if (expect_q.size() == 0) begin
                $display("ERROR: a result came out with no item in flight at %0t ns", $time);
                $display(">>> FAIL");
                $fatal(1, "extra result");
            end else begin
                e = expect_q.pop_front();
                check_value("rd", 32'(wd_o), 32'(e.rd));
                check_value("wreg", 32'(wreg_o), 32'(e.wreg));
                if (e.check_data) begin
                    check_value("wdata", wdata_o, e.wdata);
                end
                if (e.fixed_lat) begin
                    check_value("pass-through latency", cycle_cnt - e.cycle, 32'd2);
                end
            end
        end
    end

    // ------------------------------
    // stimulus
    // ------------------------------
    initial begin
        logic [31:0] r;
        logic [31:0] a;
        logic [2:0]  load_f3 [5];
        logic [2:0]  store_f3 [3];
        int          drain;
        load_f3  = '{F3_B, F3_H, F3_W, F3_BU, F3_HU};
        store_f3 = '{F3_B, F3_H, F3_W};
        rst        = 1'b1;
        in_valid_i = 1'b0;
        opcode_i   = 7'h0;
        funct3_i   = 3'h0;
        rd_i       = 5'h0;
        wreg_i     = 1'b0;
        wdata_i    = 32'h0;
        addr_i     = 32'h0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        // pass-through, aligned, sign handling, then misaligned and wrapping
        send_item(OPCODE_OP,    F3_W,  5'd1,  1'b1, 32'h12345678, 32'h0);
        send_item(OPCODE_OPIMM, F3_W,  5'd2,  1'b1, 32'hCAFEF00D, 32'h0);
        send_item(OPCODE_STORE, F3_W,  5'd3,  1'b1, 32'h89ABCDEF, 32'h100);
        send_item(OPCODE_LOAD,  F3_W,  5'd4,  1'b1, 32'h0,        32'h100);
        send_item(OPCODE_LOAD,  F3_H,  5'd5,  1'b1, 32'h0,        32'h100);
        send_item(OPCODE_LOAD,  F3_HU, 5'd6,  1'b1, 32'h0,        32'h102);
        send_item(OPCODE_LOAD,  F3_B,  5'd7,  1'b1, 32'h0,        32'h103);
        send_item(OPCODE_LOAD,  F3_BU, 5'd8,  1'b1, 32'h0,        32'h103);
        send_item(OPCODE_STORE, F3_H,  5'd9,  1'b1, 32'h55667421, 32'h104);
        send_item(OPCODE_LOAD,  F3_H,  5'd10, 1'b1, 32'h0,        32'h104);
        send_item(OPCODE_STORE, F3_B,  5'd11, 1'b1, 32'h0000AA7F, 32'h106);
        send_item(OPCODE_LOAD,  F3_B,  5'd12, 1'b1, 32'h0,        32'h106);
        send_item(OPCODE_STORE, F3_W,  5'd13, 1'b1, 32'h11223344, 32'h3FE);
        send_item(OPCODE_LOAD,  F3_W,  5'd14, 1'b1, 32'h0,        32'hFFFFF3FE);
        send_item(OPCODE_LOAD,  F3_H,  5'd15, 1'b1, 32'h0,        32'h3FF);
        send_item(OPCODE_LOAD,  F3_HU, 5'd16, 1'b1, 32'h0,        32'h001);

        // random mix in a window that wraps over the top of the ram
        for (int i = 0; i < N_RANDOM; i++) begin
            r = next_random();
            a = next_random();
            a = {a[31:ADDR_W], ADDR_W'(10'h3F0 + 10'(a[4:0]))};
            case (r[1:0])
                2'd0: send_item(OPCODE_OP, F3_W, r[8:4], r[9], next_random(), a);
                2'd1: send_item(OPCODE_LOAD, load_f3[r[14:12] % 5], r[8:4], r[9], 32'h0, a);
                2'd2: send_item(OPCODE_STORE, store_f3[r[14:12] % 3], r[8:4], r[9],
                                next_random(), a);
                default: send_item(OPCODE_OPIMM, F3_B, r[8:4], r[9], next_random(), a);
            endcase
            if (r[23:22] == 2'd0) begin
                idle_cycles(int'(r[25:24]) % 3 + 1);
            end
        end

        idle_cycles(1);
        // the last item needs at most one word access to drain
        drain = 0;
        while (expect_q.size() != 0 && drain < 20) begin
            @(posedge clk);
            drain++;
        end
        // a few more cycles to catch a duplicated result
        repeat (4) @(posedge clk);
        if (expect_q.size() != 0) begin
            $display("ERROR: %0d results never came out", expect_q.size());
            $display(">>> FAIL");
            $fatal(1, "lost results");
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

/* mem_stage_top.f */
+incdir+tb
logic/lsu_pkg.sv
logic/byte_bus_if.sv
logic/pipe_reg.sv
logic/mem_access_seq.sv
logic/byte_ram.sv
logic/mem_stage_top.sv
tb/tb_mem_stage_top.sv

/* Bender.yml */
package:
  name: mem_stage

sources:
  - files:
      - logic/lsu_pkg.sv
      - logic/byte_bus_if.sv
      - logic/pipe_reg.sv
      - logic/mem_access_seq.sv
      - logic/byte_ram.sv
      - logic/mem_stage_top.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/tb_mem_stage_top.sv
